// ==== hdl/alu.sv ====
// ALU: ten-operation integer unit for the RV32I execute slice
`timescale 1ns/1ns

module alu import rv32i_pkg::*; (
  input  alu_op_t           op_i,
  input  logic [WORD_W-1:0] a_i,
  input  logic [WORD_W-1:0] b_i,
  output logic [WORD_W-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shift amount from the low five bits only
  assign shamt = b_i[4:0];

  assign lt_signed   = ($signed(a_i) < $signed(b_i));
  assign lt_unsigned = (a_i < b_i);

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLT:  result_o = {{(WORD_W-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(WORD_W-1){1'b0}}, lt_unsigned};
      default:  result_o = a_i + b_i;
    endcase
  end

endmodule

// ==== hdl/branch_unit.sv ====
// Branch unit: resolves branch conditions and jump targets into the next pc
`timescale 1ns/1ns

module branch_unit import rv32i_pkg::*; (
  input  logic [WORD_W-1:0] pc_i,
  input  logic [WORD_W-1:0] rs1_data_i,
  input  logic [WORD_W-1:0] rs2_data_i,
  input  logic [WORD_W-1:0] imm_i,
  input  logic              branch_i,
  input  branch_t           branch_type_i,
  input  logic              jump_i,
  input  logic              j_sel_i,
  output logic              taken_o,
  output logic [WORD_W-1:0] next_pc_o
);

  logic              cond;
  logic [WORD_W-1:0] jalr_target;

  always_comb begin
    case (branch_type_i)
      BEQ:     cond = (rs1_data_i == rs2_data_i);
      BNE:     cond = (rs1_data_i != rs2_data_i);
      BLT:     cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
      BGE:     cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      BLTU:    cond = (rs1_data_i < rs2_data_i);
      BGEU:    cond = (rs1_data_i >= rs2_data_i);
      default: cond = 1'b0;
    endcase
  end

  // Jumps count as taken too
  assign taken_o = jump_i || (branch_i && cond);

  assign jalr_target = (rs1_data_i + imm_i) & ~32'd1;

  always_comb begin
    if (jump_i && !j_sel_i)
      next_pc_o = jalr_target;
    else if (taken_o)
      next_pc_o = pc_i + imm_i;
    else
      next_pc_o = pc_i + 32'd4;
  end

endmodule

// ==== hdl/control_unit.sv ====
// Control unit: combinational RV32I decode into register selects, immediate and strobes
`timescale 1ns/1ns

module control_unit import rv32i_pkg::*; (
  input  logic [WORD_W-1:0]     instr_i,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic [WORD_W-1:0]     imm_o,
  output alu_op_t               alu_op_o,
  output logic                  alu_a_pc_o,
  output logic                  alu_b_imm_o,
  output wsel_t                 w_sel_o,
  output logic                  wen_o,
  output logic                  dren_o,
  output logic                  dwen_o,
  output load_t                 load_type_o,
  output logic                  branch_o,
  output branch_t               branch_type_o,
  output logic                  jump_o,
  output logic                  j_sel_o,
  output logic                  halt_o,
  output logic                  illegal_o,
  output logic                  ecall_o,
  output logic                  ebreak_o,
  output logic                  mret_o,
  output logic                  csr_o
);

  opcode_t           opcode;
  funct3_imm_t       f3_imm;
  funct3_reg_t       f3_reg;
  system_t           f3_sys;
  priv_insn_t        sys_imm;
  logic              is_imm;
  logic              is_reg;
  logic              shift_r;
  logic              add_sub;
  logic [WORD_W-1:0] imm_i_type;
  logic [WORD_W-1:0] imm_s_type;
  logic [WORD_W-1:0] imm_sb_type;
  logic [WORD_W-1:0] imm_uj_type;
  logic [WORD_W-1:0] imm_u_type;

  assign opcode  = opcode_t'(instr_i[6:0]);
  assign f3_imm  = funct3_imm_t'(instr_i[14:12]);
  assign f3_reg  = funct3_reg_t'(instr_i[14:12]);
  assign f3_sys  = system_t'(instr_i[14:12]);
  assign sys_imm = priv_insn_t'(instr_i[31:20]);
  assign is_imm  = (opcode == IMMED);
  assign is_reg  = (opcode == REGREG);

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  // Immediate formats, all sign extended from bit 31
  assign imm_i_type  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
  assign imm_uj_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};
  assign imm_u_type  = {instr_i[31:12], 12'b0};

  always_comb begin
    case (opcode)
      STORE:      imm_o = imm_s_type;
      BRANCH:     imm_o = imm_sb_type;
      JAL:        imm_o = imm_uj_type;
      LUI, AUIPC: imm_o = imm_u_type;
      default:    imm_o = imm_i_type;
    endcase
  end

  assign load_type_o   = load_t'(instr_i[14:12]);
  assign branch_type_o = branch_t'(instr_i[14:12]);

  assign dren_o   = (opcode == LOAD);
  assign dwen_o   = (opcode == STORE);
  assign branch_o = (opcode == BRANCH);
  assign jump_o   = (opcode == JAL) || (opcode == JALR);
  assign j_sel_o  = (opcode == JAL);

  // Operand A takes the pc for AUIPC and both jumps
  assign alu_a_pc_o  = (opcode == AUIPC) || jump_o;
  // Only register ops and branches compare or combine rs2
  assign alu_b_imm_o = !(is_reg || (opcode == BRANCH));

  always_comb begin
    case (opcode)
      LOAD:      w_sel_o = WB_LOAD;
      JAL, JALR: w_sel_o = WB_LINK;
      LUI:       w_sel_o = WB_UPPER;
      default:   w_sel_o = WB_ALU;
    endcase
  end

  // System instructions report flags only and never write rd
  always_comb begin
    case (opcode)
      LUI, AUIPC, JAL, JALR, LOAD, IMMED, REGREG: wen_o = 1'b1;
      default:                                    wen_o = 1'b0;
    endcase
  end

  assign shift_r = (is_imm && f3_imm == SRI) || (is_reg && f3_reg == SR);
  assign add_sub = is_reg && (f3_reg == ADDSUB);

  // Priority chain, address arithmetic and jumps fall through to add
  always_comb begin
    if ((is_imm && f3_imm == SLLI) || (is_reg && f3_reg == SLL))
      alu_op_o = ALU_SLL;
    else if (shift_r && instr_i[30])
      alu_op_o = ALU_SRA;
    else if (shift_r)
      alu_op_o = ALU_SRL;
    else if ((is_imm && f3_imm == ADDI) || (add_sub && !instr_i[30]) ||
             opcode == AUIPC || opcode == LOAD || opcode == STORE)
      alu_op_o = ALU_ADD;
    else if (add_sub)
      alu_op_o = ALU_SUB;
    else if ((is_imm && f3_imm == ANDI) || (is_reg && f3_reg == AND))
      alu_op_o = ALU_AND;
    else if ((is_imm && f3_imm == ORI) || (is_reg && f3_reg == OR))
      alu_op_o = ALU_OR;
    else if ((is_imm && f3_imm == XORI) || (is_reg && f3_reg == XOR))
      alu_op_o = ALU_XOR;
    else if ((is_imm && f3_imm == SLTI) || (is_reg && f3_reg == SLT))
      alu_op_o = ALU_SLT;
    else if ((is_imm && f3_imm == SLTIU) || (is_reg && f3_reg == SLTU))
      alu_op_o = ALU_SLTU;
    else
      alu_op_o = ALU_ADD;
  end

  assign halt_o = (instr_i == HALT_INSN);

  always_comb begin
    case (opcode)
      REGREG:                             illegal_o = instr_i[25];
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD,
      STORE, IMMED, MISCMEM, SYSTEM:      illegal_o = 1'b0;
      default:                            illegal_o = 1'b1;
    endcase
  end

  // Privileged forms share funct3 PRIV and differ in imm[11:0]
  assign ecall_o  = (opcode == SYSTEM) && (f3_sys == PRIV) && (sys_imm == ECALL);
  assign ebreak_o = (opcode == SYSTEM) && (f3_sys == PRIV) && (sys_imm == EBREAK);
  assign mret_o   = (opcode == SYSTEM) && (f3_sys == PRIV) && (sys_imm == MRET);

  always_comb begin
    csr_o = 1'b0;
    if (opcode == SYSTEM) begin
      case (f3_sys)
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: csr_o = 1'b1;
        default:                                     csr_o = 1'b0;
      endcase
    end
  end

endmodule

// ==== hdl/exec_core.sv ====
// Execute core: RV32I single-cycle execute slice with data memory port and registered results
`timescale 1ns/1ns

module exec_core import rv32i_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  logic [WORD_W-1:0]     instr_i,
  input  logic [WORD_W-1:0]     pc_i,
  input  logic [WORD_W-1:0]     dmem_rdata_i,
  output logic [WORD_W-1:0]     dmem_addr_o,
  output logic [WORD_W-1:0]     dmem_wdata_o,
  output logic                  dmem_ren_o,
  output logic                  dmem_wen_o,
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [WORD_W-1:0]     wb_data_o,
  output logic [WORD_W-1:0]     next_pc_o,
  output logic                  branch_taken_o,
  output logic                  halt_o,
  output logic                  illegal_o,
  output logic                  ecall_o,
  output logic                  ebreak_o,
  output logic                  mret_o,
  output logic                  csr_o
);

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [WORD_W-1:0]     imm;
  alu_op_t               alu_op;
  logic                  alu_a_pc;
  logic                  alu_b_imm;
  wsel_t                 w_sel;
  logic                  cu_wen;
  logic                  cu_dren;
  logic                  cu_dwen;
  load_t                 load_type;
  logic                  branch;
  branch_t               branch_type;
  logic                  jump;
  logic                  j_sel;
  logic                  cu_halt;
  logic                  cu_illegal;
  logic                  cu_ecall;
  logic                  cu_ebreak;
  logic                  cu_mret;
  logic                  cu_csr;
  logic [WORD_W-1:0]     rs1_data;
  logic [WORD_W-1:0]     rs2_data;
  logic [WORD_W-1:0]     alu_a;
  logic [WORD_W-1:0]     alu_b;
  logic [WORD_W-1:0]     alu_result;
  logic                  taken;
  logic [WORD_W-1:0]     target_pc;
  logic                  insn_ok;
  logic                  rf_wen;
  logic [1:0]            byte_off;
  logic [7:0]            load_byte;
  logic [15:0]           load_half;
  logic [WORD_W-1:0]     load_data;
  logic [WORD_W-1:0]     wb_data;

  control_unit control_unit_inst (
    .instr_i       (instr_i),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd),
    .imm_o         (imm),
    .alu_op_o      (alu_op),
    .alu_a_pc_o    (alu_a_pc),
    .alu_b_imm_o   (alu_b_imm),
    .w_sel_o       (w_sel),
    .wen_o         (cu_wen),
    .dren_o        (cu_dren),
    .dwen_o        (cu_dwen),
    .load_type_o   (load_type),
    .branch_o      (branch),
    .branch_type_o (branch_type),
    .jump_o        (jump),
    .j_sel_o       (j_sel),
    .halt_o        (cu_halt),
    .illegal_o     (cu_illegal),
    .ecall_o       (cu_ecall),
    .ebreak_o      (cu_ebreak),
    .mret_o        (cu_mret),
    .csr_o         (cu_csr)
  );

  // Illegal instructions never write a register or touch memory
  assign insn_ok = instr_valid_i && !cu_illegal;
  assign rf_wen  = insn_ok && cu_wen;

  reg_file reg_file_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rd_i     (rd),
    .wen_i    (rf_wen),
    .wdata_i  (wb_data),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  assign alu_a = alu_a_pc ? pc_i : rs1_data;
  assign alu_b = alu_b_imm ? imm : rs2_data;

  alu alu_inst (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  branch_unit branch_unit_inst (
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .imm_i         (imm),
    .branch_i      (branch),
    .branch_type_i (branch_type),
    .jump_i        (jump),
    .j_sel_i       (j_sel),
    .taken_o       (taken),
    .next_pc_o     (target_pc)
  );

  assign dmem_addr_o  = alu_result;
  assign dmem_wdata_o = rs2_data;
  assign dmem_ren_o   = insn_ok && cu_dren;
  assign dmem_wen_o   = insn_ok && cu_dwen;

  // Pick the addressed byte or halfword out of the returned word
  assign byte_off  = alu_result[1:0];
  assign load_byte = dmem_rdata_i[{byte_off, 3'b000} +: 8];
  assign load_half = dmem_rdata_i[{byte_off[1], 4'b0000} +: 16];

  always_comb begin
    case (load_type)
      LB:      load_data = {{24{load_byte[7]}}, load_byte};
      LH:      load_data = {{16{load_half[15]}}, load_half};
      LBU:     load_data = {24'b0, load_byte};
      LHU:     load_data = {16'b0, load_half};
      default: load_data = dmem_rdata_i;
    endcase
  end

  always_comb begin
    case (w_sel)
      WB_LOAD:  wb_data = load_data;
      WB_LINK:  wb_data = pc_i + 32'd4;
      WB_UPPER: wb_data = imm;
      default:  wb_data = alu_result;
    endcase
  end

  // Results show up one cycle after the instruction, flags drop on idle cycles
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_valid_o     <= 1'b0;
      wb_rd_o        <= '0;
      wb_data_o      <= '0;
      next_pc_o      <= '0;
      branch_taken_o <= 1'b0;
      halt_o         <= 1'b0;
      illegal_o      <= 1'b0;
      ecall_o        <= 1'b0;
      ebreak_o       <= 1'b0;
      mret_o         <= 1'b0;
      csr_o          <= 1'b0;
    end else begin
      wb_valid_o     <= rf_wen;
      branch_taken_o <= instr_valid_i && taken;
      halt_o         <= instr_valid_i && cu_halt;
      illegal_o      <= instr_valid_i && cu_illegal;
      ecall_o        <= instr_valid_i && cu_ecall;
      ebreak_o       <= instr_valid_i && cu_ebreak;
      mret_o         <= instr_valid_i && cu_mret;
      csr_o          <= instr_valid_i && cu_csr;
      if (instr_valid_i) begin
        wb_rd_o   <= rd;
        wb_data_o <= wb_data;
        next_pc_o <= target_pc;
      end
    end
  end

endmodule

// ==== hdl/reg_file.sv ====
// Register file: 32 x 32-bit, two combinational read ports, one write port, x0 tied to zero
`timescale 1ns/1ns

module reg_file import rv32i_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic                  wen_i,
  input  logic [WORD_W-1:0]     wdata_i,
  output logic [WORD_W-1:0]     rdata1_o,
  output logic [WORD_W-1:0]     rdata2_o
);

  logic [WORD_W-1:0] regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 is never written, so it keeps its reset value of zero
  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

// ==== hdl/rv32i_pkg.sv ====
// RV32I execute slice shared widths, instruction encodings and control types
package rv32i_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;

  // jal x0, 0 spins on itself and is taken as the end of a program
  localparam logic [WORD_W-1:0] HALT_INSN = 32'h0000_006f;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // funct3 for immediate arithmetic
  typedef enum logic [2:0] {
    ADDI  = 3'd0,
    SLLI  = 3'd1,
    SLTI  = 3'd2,
    SLTIU = 3'd3,
    XORI  = 3'd4,
    SRI   = 3'd5,
    ORI   = 3'd6,
    ANDI  = 3'd7
  } funct3_imm_t;

  // funct3 for register arithmetic, bit 30 picks sub and sra
  typedef enum logic [2:0] {
    ADDSUB = 3'd0,
    SLL    = 3'd1,
    SLT    = 3'd2,
    SLTU   = 3'd3,
    XOR    = 3'd4,
    SR     = 3'd5,
    OR     = 3'd6,
    AND    = 3'd7
  } funct3_reg_t;

  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd4,
    LHU = 3'd5
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } branch_t;

  typedef enum logic [2:0] {
    PRIV   = 3'd0,
    CSRRW  = 3'd1,
    CSRRS  = 3'd2,
    CSRRC  = 3'd3,
    CSRRWI = 3'd5,
    CSRRSI = 3'd6,
    CSRRCI = 3'd7
  } system_t;

  // imm[11:0] of a PRIV system instruction
  typedef enum logic [11:0] {
    ECALL  = 12'h000,
    EBREAK = 12'h001,
    MRET   = 12'h302
  } priv_insn_t;

  typedef enum logic [1:0] {
    WB_LOAD  = 2'd0,
    WB_LINK  = 2'd1,
    WB_UPPER = 2'd2,
    WB_ALU   = 2'd3
  } wsel_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build exec_core_tb with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module exec_core_tb -o exec_core_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/exec_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi

// ==== testbench/exec_core_tb.sv ====
// Testbench for the RV32I execute slice, replays stimulus entries and checks registered results
`timescale 1ns/1ns

module exec_core_tb import rv32i_pkg::*; ();

  localparam int    CLK_HALF     = 4;
  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 4;
  localparam int    MAX_GAP      = 3;
  localparam int    MAX_LINES    = 64;
  localparam int    RAND_SEED    = 79972;
  localparam string STIM_FILE    = "testbench/exec_stim.txt";

  logic                  clk_i;
  logic                  rst_i;
  logic                  instr_valid_i;
  logic [WORD_W-1:0]     instr_i;
  logic [WORD_W-1:0]     pc_i;
  logic [WORD_W-1:0]     dmem_rdata_i;
  logic [WORD_W-1:0]     dmem_addr_o;
  logic [WORD_W-1:0]     dmem_wdata_o;
  logic                  dmem_ren_o;
  logic                  dmem_wen_o;
  logic                  wb_valid_o;
  logic [REG_ADDR_W-1:0] wb_rd_o;
  logic [WORD_W-1:0]     wb_data_o;
  logic [WORD_W-1:0]     next_pc_o;
  logic                  branch_taken_o;
  logic                  halt_o;
  logic                  illegal_o;
  logic                  ecall_o;
  logic                  ebreak_o;
  logic                  mret_o;
  logic                  csr_o;

  // Stimulus entries
  // Expected flags pack as {halt, illegal, ecall, ebreak, mret, csr}
  logic [WORD_W-1:0]     s_instr [MAX_LINES];
  logic [WORD_W-1:0]     s_pc    [MAX_LINES];
  logic [WORD_W-1:0]     s_rdata [MAX_LINES];
  logic                  s_valid [MAX_LINES];
  logic [REG_ADDR_W-1:0] s_rd    [MAX_LINES];
  logic [WORD_W-1:0]     s_data  [MAX_LINES];
  logic [WORD_W-1:0]     s_npc   [MAX_LINES];
  logic                  s_taken [MAX_LINES];
  logic [5:0]            s_flags [MAX_LINES];
  logic                  s_ren   [MAX_LINES];
  logic                  s_wen   [MAX_LINES];
  logic [WORD_W-1:0]     s_addr  [MAX_LINES];
  logic [WORD_W-1:0]     s_wdata [MAX_LINES];

  int n_entries   = 0;
  int cur_entry   = -1;
  int watch_cycles = 0;
  int word_errs   = 0;
  int reg_errs    = 0;
  int bit_errs    = 0;
  int mem_errs    = 0;
  int other_errs  = 0;

  exec_core exec_core_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .dmem_rdata_i   (dmem_rdata_i),
    .dmem_addr_o    (dmem_addr_o),
    .dmem_wdata_o   (dmem_wdata_o),
    .dmem_ren_o     (dmem_ren_o),
    .dmem_wen_o     (dmem_wen_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o),
    .next_pc_o      (next_pc_o),
    .branch_taken_o (branch_taken_o),
    .halt_o         (halt_o),
    .illegal_o      (illegal_o),
    .ecall_o        (ecall_o),
    .ebreak_o       (ebreak_o),
    .mret_o         (mret_o),
    .csr_o          (csr_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      word_errs++;
      $display("error: %s got 0x%08h expected 0x%08h at entry %0d", name, got, exp, cur_entry);
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] got,
                           input logic [REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      reg_errs++;
      $display("error: %s got 0x%02h expected 0x%02h at entry %0d", name, got, exp, cur_entry);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("error: %s got 0x%0h expected 0x%0h at entry %0d", name, got, exp, cur_entry);
    end
  endtask

  // Address is checked for any access, write data only for stores
  task automatic check_mem(input logic ren, input logic wen, input logic [WORD_W-1:0] addr,
                           input logic [WORD_W-1:0] wdata, input int idx);
    if (ren !== s_ren[idx]) begin
      mem_errs++;
      $display("error: dmem_ren_o got 0x%0h expected 0x%0h at entry %0d", ren, s_ren[idx], idx);
    end
    if (wen !== s_wen[idx]) begin
      mem_errs++;
      $display("error: dmem_wen_o got 0x%0h expected 0x%0h at entry %0d", wen, s_wen[idx], idx);
    end
    if ((s_ren[idx] || s_wen[idx]) && addr !== s_addr[idx]) begin
      mem_errs++;
      $display("error: dmem_addr_o got 0x%08h expected 0x%08h at entry %0d",
               addr, s_addr[idx], idx);
    end
    if (s_wen[idx] && wdata !== s_wdata[idx]) begin
      mem_errs++;
      $display("error: dmem_wdata_o got 0x%08h expected 0x%08h at entry %0d",
               wdata, s_wdata[idx], idx);
    end
  endtask

  task automatic check_flags(input logic [5:0] exp);
    check_bit("halt_o", halt_o, exp[5]);
    check_bit("illegal_o", illegal_o, exp[4]);
    check_bit("ecall_o", ecall_o, exp[3]);
    check_bit("ebreak_o", ebreak_o, exp[2]);
    check_bit("mret_o", mret_o, exp[1]);
    check_bit("csr_o", csr_o, exp[0]);
  endtask

  task automatic check_idle();
    check_bit("dmem_ren_o", dmem_ren_o, 1'b0);
    check_bit("dmem_wen_o", dmem_wen_o, 1'b0);
    check_bit("wb_valid_o", wb_valid_o, 1'b0);
    check_bit("branch_taken_o", branch_taken_o, 1'b0);
    check_flags(6'h00);
  endtask

  task automatic check_reset_state();
    check_idle();
    check_reg("wb_rd_o", wb_rd_o, '0);
    check_word("wb_data_o", wb_data_o, '0);
    check_word("next_pc_o", next_pc_o, '0);
  endtask

  task automatic load_stim();
    int          fd;
    string       line;
    logic [31:0] f_instr, f_pc, f_rdata, f_valid, f_rd, f_data, f_npc;
    logic [31:0] f_taken, f_flags, f_ren, f_wen, f_addr, f_wdata;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      other_errs++;
      $display("Stimulus file %s could not be opened", STIM_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip comment and blank lines
      if (line.len() < 8 || line.getc(0) == "#")
        continue;
      if (n_entries >= MAX_LINES) begin
        other_errs++;
        $display("Stimulus file holds more than %0d entries", MAX_LINES);
        break;
      end
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f_instr, f_pc, f_rdata,
                  f_valid, f_rd, f_data, f_npc, f_taken, f_flags, f_ren, f_wen, f_addr,
                  f_wdata) != 13) begin
        other_errs++;
        $display("Malformed stimulus line: %s", line);
        continue;
      end
      s_instr[n_entries] = f_instr;
      s_pc[n_entries]    = f_pc;
      s_rdata[n_entries] = f_rdata;
      s_valid[n_entries] = f_valid[0];
      s_rd[n_entries]    = f_rd[REG_ADDR_W-1:0];
      s_data[n_entries]  = f_data;
      s_npc[n_entries]   = f_npc;
      s_taken[n_entries] = f_taken[0];
      s_flags[n_entries] = f_flags[5:0];
      s_ren[n_entries]   = f_ren[0];
      s_wen[n_entries]   = f_wen[0];
      s_addr[n_entries]  = f_addr;
      s_wdata[n_entries] = f_wdata;
      n_entries++;
    end
    $fclose(fd);
    if (n_entries == 0) begin
      other_errs++;
      $display("No stimulus entries were read");
    end
  endtask

  // Entered 1 ns after a rising edge, leaves at the same point of a later cycle
  task automatic run_entry(input int idx);
    int gap;
    cur_entry     = idx;
    instr_valid_i = 1'b1;
    instr_i       = s_instr[idx];
    pc_i          = s_pc[idx];
    dmem_rdata_i  = s_rdata[idx];
    #3;
    check_mem(dmem_ren_o, dmem_wen_o, dmem_addr_o, dmem_wdata_o, idx);
    @(posedge clk_i);
    #1;
    check_bit("wb_valid_o", wb_valid_o, s_valid[idx]);
    if (s_valid[idx]) begin
      check_reg("wb_rd_o", wb_rd_o, s_rd[idx]);
      check_word("wb_data_o", wb_data_o, s_data[idx]);
    end
    check_word("next_pc_o", next_pc_o, s_npc[idx]);
    check_bit("branch_taken_o", branch_taken_o, s_taken[idx]);
    check_flags(s_flags[idx]);
    // The last instruction stays on the bus while the strobe is low
    instr_valid_i = 1'b0;
    gap = int'($urandom % (MAX_GAP + 1));
    repeat (gap) begin
      @(posedge clk_i);
      #1;
      check_idle();
    end
  endtask

  // Watchdog sized from the entry count once the file is loaded
  initial begin
    wait (watch_cycles > 0);
    #(watch_cycles * CLK_PERIOD);
    other_errs++;
    $display("Timeout: run did not finish within %0d clock cycles", watch_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int total_errs;
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    dmem_rdata_i  = '0;
    void'($urandom(RAND_SEED));
    load_stim();
    watch_cycles = n_entries * (MAX_GAP + 1) + 20;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    check_reset_state();
    rst_i = 1'b0;

    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end

    // A second reset must clear whatever the program left behind
    cur_entry = -1;
    rst_i     = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    check_reset_state();
    rst_i = 1'b0;

    total_errs = word_errs + reg_errs + bit_errs + mem_errs + other_errs;
    $display("Summary: %0d entries, word errors %0d, reg errors %0d, bit errors %0d, %s %0d, %s %0d",
             n_entries, word_errs, reg_errs, bit_errs, "mem errors", mem_errs,
             "other errors", other_errs);
    if (total_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== testbench/exec_stim.txt ====
# instr pc dmem_rdata | wb_valid wb_rd wb_data next_pc taken flags | ren wen addr wdata
# flags = {halt, illegal, ecall, ebreak, mret, csr}, all fields hex
00500093 00000100 00000000 1 01 00000005 00000104 0 00 0 0 00000000 00000000
80000137 00000104 00000000 1 02 80000000 00000108 0 00 0 0 00000000 00000000
FF800193 00000108 00000000 1 03 FFFFFFF8 0000010C 0 00 0 0 00000000 00000000
00308233 0000010C 00000000 1 04 FFFFFFFD 00000110 0 00 0 0 00000000 00000000
403082B3 00000110 00000000 1 05 0000000D 00000114 0 00 0 0 00000000 00000000
00109333 00000114 00000000 1 06 000000A0 00000118 0 00 0 0 00000000 00000000
001153B3 00000118 00000000 1 07 04000000 0000011C 0 00 0 0 00000000 00000000
40115433 0000011C 00000000 1 08 FC000000 00000120 0 00 0 0 00000000 00000000
003274B3 00000120 00000000 1 09 FFFFFFF8 00000124 0 00 0 0 00000000 00000000
0020E533 00000124 00000000 1 0A 80000005 00000128 0 00 0 0 00000000 00000000
001245B3 00000128 00000000 1 0B FFFFFFF8 0000012C 0 00 0 0 00000000 00000000
0011A633 0000012C 00000000 1 0C 00000001 00000130 0 00 0 0 00000000 00000000
0011B6B3 00000130 00000000 1 0D 00000000 00000134 0 00 0 0 00000000 00000000
40415793 00000134 00000000 1 0F F8000000 00000138 0 00 0 0 00000000 00000000
00708013 00000138 00000000 1 00 0000000C 0000013C 0 00 0 0 00000000 00000000
001048B3 0000013C 00000000 1 11 00000005 00000140 0 00 0 0 00000000 00000000
00B18863 00000140 00000000 0 00 00000000 00000150 1 00 0 0 00000000 00000000
00308863 00000144 00000000 0 00 00000000 00000148 0 00 0 0 00000000 00000000
00309863 00000148 00000000 0 00 00000000 00000158 1 00 0 0 00000000 00000000
00B19863 0000014C 00000000 0 00 00000000 00000150 0 00 0 0 00000000 00000000
0011C863 00000150 00000000 0 00 00000000 00000160 1 00 0 0 00000000 00000000
0030C863 00000154 00000000 0 00 00000000 00000158 0 00 0 0 00000000 00000000
0030D863 00000158 00000000 0 00 00000000 00000168 1 00 0 0 00000000 00000000
0011D863 0000015C 00000000 0 00 00000000 00000160 0 00 0 0 00000000 00000000
0030E863 00000160 00000000 0 00 00000000 00000170 1 00 0 0 00000000 00000000
0011E863 00000164 00000000 0 00 00000000 00000168 0 00 0 0 00000000 00000000
FE11FCE3 00000168 00000000 0 00 00000000 00000160 1 00 0 0 00000000 00000000
0030F863 0000016C 00000000 0 00 00000000 00000170 0 00 0 0 00000000 00000000
0200096F 00000170 00000000 1 12 00000174 00000190 1 00 0 0 00000000 00000000
003309E7 00000174 00000000 1 13 00000178 000000A2 1 00 0 0 00000000 00000000
00432423 00000178 00000000 0 00 00000000 0000017C 0 00 0 1 000000A8 FFFFFFFD
00130A03 0000017C 92F4A688 1 14 FFFFFFA6 00000180 0 00 1 0 000000A1 00000000
00330A83 00000180 92F4A688 1 15 FFFFFF92 00000184 0 00 1 0 000000A3 00000000
00234B03 00000184 92F4A688 1 16 000000F4 00000188 0 00 1 0 000000A2 00000000
00231B83 00000188 92F4A688 1 17 FFFF92F4 0000018C 0 00 1 0 000000A2 00000000
00035C03 0000018C 92F4A688 1 18 0000A688 00000190 0 00 1 0 000000A0 00000000
00030C83 00000190 92F4A688 1 19 FFFFFF88 00000194 0 00 1 0 000000A0 00000000
00000073 00000194 00000000 0 00 00000000 00000198 0 08 0 0 00000000 00000000
00100073 00000198 00000000 0 00 00000000 0000019C 0 04 0 0 00000000 00000000
30200073 0000019C 00000000 0 00 00000000 000001A0 0 02 0 0 00000000 00000000
34009D73 000001A0 00000000 0 00 00000000 000001A4 0 01 0 0 00000000 00000000
0000006F 000001A4 00000000 1 00 000001A8 000001A4 1 20 0 0 00000000 00000000
0000007F 000001A8 00000000 0 00 00000000 000001AC 0 10 0 0 00000000 00000000
02108DB3 000001AC 00000000 0 00 00000000 000001B0 0 10 0 0 00000000 00000000
000D8E33 000001B0 00000000 1 1C 00000000 000001B4 0 00 0 0 00000000 00000000

// ==== verilog.f ====
hdl/rv32i_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/exec_core.sv
testbench/exec_core_tb.sv
